// ==== Makefile ====
VERILATOR ?= verilator
TOP       := sdio_data_control_tb
FILELIST  := verilog.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
SIM       := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Finished with errors
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/sdio_data_control.sv ====
`default_nettype none

module sdio_data_control #(
  parameter  int NUM_IO_FUNCS = sdio_data_pkg::NUM_IO_FUNCS_DEFAULT,
  localparam int SEL_W        = $clog2(NUM_IO_FUNCS + 1)
) (
  input  wire                                    clk,
  input  wire                                    rst,

  // Transfer setup
  input  wire                                    i_block_mode_flg,
  input  wire sdio_data_pkg::count_t             i_data_cnt,
  output sdio_data_pkg::count_t                  o_total_data_cnt,
  input  wire                                    i_inc_addr_flg,
  input  wire sdio_data_pkg::addr_t              i_cmd_address,
  output sdio_data_pkg::addr_t                   o_address,
  input  wire                                    i_activate,
  output logic                                   o_finished,
  input  wire                                    i_mem_sel,
  input  wire        [SEL_W-1:0]                 i_func_sel,

  // Data PHY
  input  wire                                    i_data_phy_wr_stb,
  input  wire sdio_data_pkg::byte_t              i_data_phy_wr_data,
  output logic                                   o_data_phy_rd_stb,
  output sdio_data_pkg::byte_t                   o_data_phy_rd_data,
  output logic                                   o_data_phy_com_rdy,
  output logic                                   o_data_phy_activate,

  // Functions 0 to NUM_IO_FUNCS-1 then memory
  output logic       [NUM_IO_FUNCS:0]            o_func_wr_stb,
  output sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0] o_func_wr_data,
  input  wire        [NUM_IO_FUNCS:0]            i_func_rd_stb,
  input  wire sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0] i_func_rd_data,
  output logic       [NUM_IO_FUNCS:0]            o_func_hst_rdy,
  input  wire        [NUM_IO_FUNCS:0]            i_func_com_rdy,
  output logic       [NUM_IO_FUNCS:0]            o_func_activate,
  input  wire sdio_data_pkg::count_t [NUM_IO_FUNCS:0] i_func_block_size
);

  sdio_func_channel_if chan ();

  // PHY end of the channel
  assign chan.wr_stb         = i_data_phy_wr_stb;
  assign chan.wr_data        = i_data_phy_wr_data;
  assign o_data_phy_rd_stb   = chan.rd_stb;
  assign o_data_phy_rd_data  = chan.rd_data;
  assign o_data_phy_com_rdy  = chan.com_rdy;
  assign o_data_phy_activate = i_activate;

  sdio_func_router #(
    .NUM_IO_FUNCS (NUM_IO_FUNCS)
  ) u_func_router (
    .i_func_sel   (i_func_sel),
    .i_mem_sel    (i_mem_sel),
    .i_activate   (i_activate),
    .i_rd_stb     (i_func_rd_stb),
    .i_rd_data    (i_func_rd_data),
    .i_com_rdy    (i_func_com_rdy),
    .i_block_size (i_func_block_size),
    .o_wr_stb     (o_func_wr_stb),
    .o_wr_data    (o_func_wr_data),
    .o_hst_rdy    (o_func_hst_rdy),
    .o_activate   (o_func_activate),
    .chan         (chan.router)
  );

  sdio_transfer_seq u_transfer_seq (
    .clk              (clk),
    .rst              (rst),
    .i_activate       (i_activate),
    .i_block_mode_flg (i_block_mode_flg),
    .i_data_cnt       (i_data_cnt),
    .i_inc_addr_flg   (i_inc_addr_flg),
    .i_cmd_address    (i_cmd_address),
    .o_total_data_cnt (o_total_data_cnt),
    .o_address        (o_address),
    .o_finished       (o_finished),
    .chan             (chan.seq)
  );

endmodule

`default_nettype wire

// ==== rtl/sdio_data_pkg.sv ====
`default_nettype none

package sdio_data_pkg;

  // Data path widths
  localparam int BYTE_W  = 8;
  localparam int ADDR_W  = 18;
  localparam int COUNT_W = 13;

  // One data byte on the PHY and target buses
  typedef logic [BYTE_W-1:0]  byte_t;

  // Register or memory address
  typedef logic [ADDR_W-1:0]  addr_t;

  // Byte count, block count and block size
  typedef logic [COUNT_W-1:0] count_t;

  // Length of a byte mode run when the count is zero
  localparam count_t DEFAULT_BYTE_LEN = count_t'(512);

  // I/O functions including the CIA at index 0
  // Memory target lives at index NUM_IO_FUNCS
  localparam int NUM_IO_FUNCS_DEFAULT = 8;

  // Transfer sequencer states
  typedef enum logic [1:0] {
    IDLE     = 2'd0,
    CONFIG   = 2'd1,
    ACTIVE   = 2'd2,
    FINISHED = 2'd3
  } xfer_state_t;

endpackage

`default_nettype wire

// ==== rtl/sdio_func_channel_if.sv ====
`default_nettype none

interface sdio_func_channel_if;

  // Write path from the PHY
  logic                  wr_stb;
  sdio_data_pkg::byte_t  wr_data;

  // Read path and status of the selected target
  logic                  rd_stb;
  sdio_data_pkg::byte_t  rd_data;
  logic                  com_rdy;
  sdio_data_pkg::count_t block_size;

  // High while the sequencer takes bytes
  logic                  hst_rdy;

  modport router (
    input  wr_stb, wr_data, hst_rdy,
    output rd_stb, rd_data, com_rdy, block_size
  );

  modport seq (
    input  wr_stb, rd_stb, block_size,
    output hst_rdy
  );

  modport phy (
    input  rd_stb, rd_data, com_rdy,
    output wr_stb, wr_data
  );

endinterface

`default_nettype wire

// ==== rtl/sdio_func_router.sv ====
`default_nettype none

module sdio_func_router #(
  parameter  int NUM_IO_FUNCS = sdio_data_pkg::NUM_IO_FUNCS_DEFAULT,
  localparam int SEL_W        = $clog2(NUM_IO_FUNCS + 1)
) (
  input  wire        [SEL_W-1:0]                 i_func_sel,
  input  wire                                    i_mem_sel,
  input  wire                                    i_activate,

  // Target side, one entry per target
  input  wire        [NUM_IO_FUNCS:0]            i_rd_stb,
  input  wire sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0] i_rd_data,
  input  wire        [NUM_IO_FUNCS:0]            i_com_rdy,
  input  wire sdio_data_pkg::count_t [NUM_IO_FUNCS:0] i_block_size,
  output logic       [NUM_IO_FUNCS:0]            o_wr_stb,
  output sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0] o_wr_data,
  output logic       [NUM_IO_FUNCS:0]            o_hst_rdy,
  output logic       [NUM_IO_FUNCS:0]            o_activate,

  sdio_func_channel_if.router                    chan
);

  localparam int NUM_TGT = NUM_IO_FUNCS + 1;

  logic [SEL_W-1:0] tgt_sel;

  // Memory select wins over the function number
  assign tgt_sel = i_mem_sel ? SEL_W'(NUM_IO_FUNCS) : i_func_sel;

  // PHY and sequencer toward the selected target only
  always_comb begin
    o_wr_stb   = '0;
    o_wr_data  = '0;
    o_hst_rdy  = '0;
    o_activate = '0;
    for (int i = 0; i < NUM_TGT; i++) begin
      if (tgt_sel == SEL_W'(i)) begin
        o_wr_stb[i]   = chan.wr_stb;
        o_wr_data[i]  = chan.wr_data;
        o_hst_rdy[i]  = chan.hst_rdy;
        o_activate[i] = i_activate;
      end
    end
  end

  // Selected target back onto the channel
  always_comb begin
    chan.rd_stb     = 1'b0;
    chan.rd_data    = '0;
    chan.com_rdy    = 1'b0;
    chan.block_size = '0;
    for (int i = 0; i < NUM_TGT; i++) begin
      if (tgt_sel == SEL_W'(i)) begin
        chan.rd_stb     = i_rd_stb[i];
        chan.rd_data    = i_rd_data[i];
        // PHY only proceeds when both ends are ready
        chan.com_rdy    = i_com_rdy[i] & chan.hst_rdy;
        chan.block_size = i_block_size[i];
      end
    end
  end

  // At most one target sees a write
  always_comb begin
    a_single_wr_stb: assert ($onehot0(o_wr_stb))
      else $error("more than one target write strobe: %b", o_wr_stb);
  end

endmodule

`default_nettype wire

// ==== rtl/sdio_transfer_seq.sv ====
`default_nettype none

module sdio_transfer_seq (
  input  wire                          clk,
  input  wire                          rst,

  input  wire                          i_activate,
  input  wire                          i_block_mode_flg,
  input  wire sdio_data_pkg::count_t   i_data_cnt,
  input  wire                          i_inc_addr_flg,
  input  wire sdio_data_pkg::addr_t    i_cmd_address,

  output sdio_data_pkg::count_t        o_total_data_cnt,
  output sdio_data_pkg::addr_t         o_address,
  output logic                         o_finished,

  sdio_func_channel_if.seq             chan
);

  sdio_data_pkg::xfer_state_t state;
  sdio_data_pkg::count_t      total_block_cnt;
  sdio_data_pkg::count_t      block_cnt;
  sdio_data_pkg::count_t      byte_cnt;
  logic                       continuous;
  logic                       byte_acc;

  // Ready until the current block is complete
  assign chan.hst_rdy = (state == sdio_data_pkg::ACTIVE) && (byte_cnt < o_total_data_cnt);

  // Only strobes seen while ready move a byte
  assign byte_acc = chan.hst_rdy && (chan.wr_stb || chan.rd_stb);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= sdio_data_pkg::IDLE;
      o_finished       <= 1'b0;
      o_total_data_cnt <= '0;
      o_address        <= '0;
      total_block_cnt  <= '0;
      block_cnt        <= '0;
      byte_cnt         <= '0;
      continuous       <= 1'b0;
    end else begin
      case (state)
        sdio_data_pkg::IDLE: begin
          o_finished      <= 1'b0;
          o_address       <= i_cmd_address;
          block_cnt       <= '0;
          byte_cnt        <= '0;
          // Zero blocks in block mode runs until activate drops
          continuous      <= i_block_mode_flg && (i_data_cnt == '0);
          total_block_cnt <= i_block_mode_flg ? i_data_cnt : '0;
          if (i_activate) begin
            state <= sdio_data_pkg::CONFIG;
          end
        end
        sdio_data_pkg::CONFIG: begin
          byte_cnt <= '0;
          if (i_block_mode_flg) begin
            o_total_data_cnt <= chan.block_size;
            if (!continuous) begin
              block_cnt <= block_cnt + sdio_data_pkg::count_t'(1);
            end
          end else if (i_data_cnt == '0) begin
            o_total_data_cnt <= sdio_data_pkg::DEFAULT_BYTE_LEN;
          end else begin
            o_total_data_cnt <= i_data_cnt;
          end
          state <= sdio_data_pkg::ACTIVE;
        end
        sdio_data_pkg::ACTIVE: begin
          if (byte_cnt < o_total_data_cnt) begin
            if (byte_acc) begin
              byte_cnt <= byte_cnt + sdio_data_pkg::count_t'(1);
              if (i_inc_addr_flg) begin
                o_address <= o_address + sdio_data_pkg::addr_t'(1);
              end
            end
          end else if (continuous || (block_cnt < total_block_cnt)) begin
            state <= sdio_data_pkg::CONFIG;
          end else begin
            state <= sdio_data_pkg::FINISHED;
          end
        end
        sdio_data_pkg::FINISHED: begin
          o_finished <= 1'b1;
        end
        default: begin
          state <= sdio_data_pkg::IDLE;
        end
      endcase

      // Activate low aborts or closes the transfer
      if (!i_activate) begin
        state      <= sdio_data_pkg::IDLE;
        o_finished <= 1'b0;
      end
    end
  end

  // Strobe counting must stop at the block length
  a_cnt_in_range: assert property (@(posedge clk) disable iff (rst)
    byte_cnt <= o_total_data_cnt)
    else $error("byte count %0d beyond length %0d", byte_cnt, o_total_data_cnt);

  // PHY writes and target reads never overlap
  a_one_direction: assert property (@(posedge clk) disable iff (rst)
    !(chan.wr_stb && chan.rd_stb))
    else $error("write and read strobe high together");

endmodule

`default_nettype wire

// ==== sim/sdio_data_control_tb.sv ====
`default_nettype none

module sdio_data_control_tb;

  localparam int NUM_IO_FUNCS = sdio_data_pkg::NUM_IO_FUNCS_DEFAULT;
  localparam int SEL_W        = $clog2(NUM_IO_FUNCS + 1);
  localparam int NUM_ROWS     = 7;

  // One transfer per row
  // Zero abort_at runs to the finish
  typedef struct packed {
    logic [SEL_W-1:0]      func_sel;
    logic                  mem_sel;
    logic                  blk_mode;
    sdio_data_pkg::count_t data_cnt;
    sdio_data_pkg::count_t blk_size;
    logic                  inc_addr;
    logic                  rd_dir;
    sdio_data_pkg::addr_t  start_addr;
    int                    abort_at;
    logic                  bp;
    int                    exp_bytes;
    sdio_data_pkg::addr_t  exp_addr;
  } row_t;

  logic                                         clk = 1'b0;
  logic                                         rst;
  logic                                         block_mode_flg;
  sdio_data_pkg::count_t                        data_cnt;
  logic                                         inc_addr_flg;
  sdio_data_pkg::addr_t                         cmd_address;
  logic                                         activate;
  logic                                         mem_sel;
  logic [SEL_W-1:0]                             func_sel;
  logic                                         phy_wr_stb;
  sdio_data_pkg::byte_t                         phy_wr_data;
  logic                  [NUM_IO_FUNCS:0]       func_rd_stb;
  sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0]       func_rd_data;
  logic                  [NUM_IO_FUNCS:0]       func_com_rdy;
  sdio_data_pkg::count_t [NUM_IO_FUNCS:0]       func_block_size;

  sdio_data_pkg::count_t                        total_data_cnt;
  sdio_data_pkg::addr_t                         address;
  logic                                         finished;
  logic                                         phy_rd_stb;
  sdio_data_pkg::byte_t                         phy_rd_data;
  logic                                         phy_com_rdy;
  logic                                         phy_activate;
  logic                  [NUM_IO_FUNCS:0]       func_wr_stb;
  sdio_data_pkg::byte_t  [NUM_IO_FUNCS:0]       func_wr_data;
  logic                  [NUM_IO_FUNCS:0]       func_hst_rdy;
  logic                  [NUM_IO_FUNCS:0]       func_activate;

  row_t   rows [NUM_ROWS];
  int     errors    = 0;
  int     checks    = 0;
  int     wd_cycles = 0;
  integer seed      = 32'h7911;

  sdio_data_control #(
    .NUM_IO_FUNCS (NUM_IO_FUNCS)
  ) i_sdio_data_control (
    .clk                 (clk),
    .rst                 (rst),
    .i_block_mode_flg    (block_mode_flg),
    .i_data_cnt          (data_cnt),
    .o_total_data_cnt    (total_data_cnt),
    .i_inc_addr_flg      (inc_addr_flg),
    .i_cmd_address       (cmd_address),
    .o_address           (address),
    .i_activate          (activate),
    .o_finished          (finished),
    .i_mem_sel           (mem_sel),
    .i_func_sel          (func_sel),
    .i_data_phy_wr_stb   (phy_wr_stb),
    .i_data_phy_wr_data  (phy_wr_data),
    .o_data_phy_rd_stb   (phy_rd_stb),
    .o_data_phy_rd_data  (phy_rd_data),
    .o_data_phy_com_rdy  (phy_com_rdy),
    .o_data_phy_activate (phy_activate),
    .o_func_wr_stb       (func_wr_stb),
    .o_func_wr_data      (func_wr_data),
    .i_func_rd_stb       (func_rd_stb),
    .i_func_rd_data      (func_rd_data),
    .o_func_hst_rdy      (func_hst_rdy),
    .i_func_com_rdy      (func_com_rdy),
    .o_func_activate     (func_activate),
    .i_func_block_size   (func_block_size)
  );

  always #4 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL time %0t: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic load_table();
    //         func   mem   blk   cnt     bsize   inc   rd    start      abort bp   bytes addr
    rows[0] = '{4'd3, 1'b0, 1'b0, 13'd20, 13'd0,  1'b1, 1'b0, 18'h00100, 0,  1'b0, 20,  18'h00114};
    rows[1] = '{4'd2, 1'b1, 1'b0, 13'd17, 13'd0,  1'b0, 1'b1, 18'h2A5F0, 0,  1'b0, 17,  18'h2A5F0};
    rows[2] = '{4'd0, 1'b0, 1'b0, 13'd0,  13'd0,  1'b1, 1'b0, 18'h01000, 0,  1'b0, 512, 18'h01200};
    rows[3] = '{4'd5, 1'b0, 1'b1, 13'd3,  13'd24, 1'b1, 1'b1, 18'h00400, 0,  1'b0, 72,  18'h00448};
    rows[4] = '{4'd1, 1'b0, 1'b1, 13'd0,  13'd16, 1'b1, 1'b0, 18'h00000, 40, 1'b0, 40,  18'h00028};
    rows[5] = '{4'd7, 1'b0, 1'b0, 13'd30, 13'd0,  1'b1, 1'b0, 18'h3FF00, 0,  1'b1, 30,  18'h3FF1E};
    rows[6] = '{4'd6, 1'b0, 1'b1, 13'd2,  13'd10, 1'b0, 1'b1, 18'h00155, 0,  1'b1, 20,  18'h00155};
  endtask

  // Expected length of each block
  // A zero byte count stands for 512
  function automatic sdio_data_pkg::count_t block_len(input row_t r);
    if (r.blk_mode) begin
      return r.blk_size;
    end
    if (r.data_cnt == '0) begin
      return 13'd512;
    end
    return r.data_cnt;
  endfunction

  task automatic run_row(input row_t r);
    int          tgt;
    int          moved;
    int          len;
    int          blk_moved;
    int          blk_left;
    int          cfg_wait;
    logic        done;
    logic        rdy;
    logic        exp_rdy;
    logic [31:0] rnd;
    tgt = r.mem_sel ? NUM_IO_FUNCS : int'(r.func_sel);
    len = int'(block_len(r));
    // Blocks that follow the first one
    // Negative keeps going until the abort
    if (!r.blk_mode) begin
      blk_left = 0;
    end else if (r.data_cnt == '0) begin
      blk_left = -1;
    end else begin
      blk_left = int'(r.data_cnt) - 1;
    end
    @(negedge clk);
    block_mode_flg = r.blk_mode;
    data_cnt       = r.data_cnt;
    inc_addr_flg   = r.inc_addr;
    cmd_address    = r.start_addr;
    mem_sel        = r.mem_sel;
    func_sel       = r.func_sel;
    for (int t = 0; t <= NUM_IO_FUNCS; t++) begin
      func_block_size[t] = (t == tgt) ? r.blk_size : sdio_data_pkg::count_t'(5 + t);
    end
    func_com_rdy = '1;
    activate     = 1'b1;
    moved        = 0;
    blk_moved    = 0;
    cfg_wait     = 1;
    done         = 1'b0;
    while (!done) begin
      @(negedge clk);
      // Strobes driven last falling edge were taken on the rising edge
      if (phy_wr_stb) begin
        moved++;
        blk_moved++;
        check_eq("o_func_wr_data", 32'(func_wr_data[tgt]), 32'(phy_wr_data));
      end
      if (func_rd_stb[tgt]) begin
        moved++;
        blk_moved++;
        check_eq("o_data_phy_rd_data", 32'(phy_rd_data), 32'(func_rd_data[tgt]));
      end
      // Host ready is low in CONFIG and on the cycle after a block's last byte
      if (cfg_wait > 0) begin
        exp_rdy = 1'b0;
        cfg_wait--;
      end else if (blk_moved == len) begin
        exp_rdy = 1'b0;
        if (blk_left != 0) begin
          blk_left--;
          blk_moved = 0;
          cfg_wait  = 1;
        end
      end else begin
        exp_rdy = 1'b1;
      end
      check_eq("o_func_hst_rdy", 32'(func_hst_rdy), 32'(exp_rdy) << tgt);
      check_eq("o_func_wr_stb", 32'(func_wr_stb), 32'(phy_wr_stb) << tgt);
      check_eq("o_data_phy_rd_stb", 32'(phy_rd_stb), 32'(func_rd_stb[tgt]));
      check_eq("o_data_phy_com_rdy", 32'(phy_com_rdy),
               32'(func_com_rdy[tgt] & exp_rdy));
      check_eq("o_data_phy_activate", 32'(phy_activate), 32'(activate));
      if (r.abort_at != 0) begin
        check_eq("o_finished", 32'(finished), 0);
        done = (moved == r.abort_at);
      end else begin
        done = finished;
      end
      phy_wr_stb  = 1'b0;
      func_rd_stb = '0;
      if (!done) begin
        rnd = $random(seed);
        rdy = r.bp ? (rnd[0] | rnd[1]) : 1'b1;
        func_com_rdy[tgt] = rdy;
        // PHY ready for this cycle is target ready and host ready
        if (func_hst_rdy[tgt] && rdy) begin
          if (!r.rd_dir) begin
            phy_wr_stb  = 1'b1;
            phy_wr_data = rnd[23:16];
          end else if (func_activate[tgt]) begin
            func_rd_stb[tgt]  = 1'b1;
            func_rd_data[tgt] = rnd[15:8];
          end
        end
      end
    end
    if (r.abort_at == 0) begin
      check_eq("moved byte count", moved, r.exp_bytes);
    end
    check_eq("o_address", 32'(address), 32'(r.exp_addr));
    check_eq("o_total_data_cnt", 32'(total_data_cnt), 32'(block_len(r)));
    activate     = 1'b0;
    func_com_rdy = '1;
    @(negedge clk);
    check_eq("o_finished", 32'(finished), 0);
    check_eq("o_func_hst_rdy", 32'(func_hst_rdy), 0);
    check_eq("o_func_activate", 32'(func_activate), 0);
    check_eq("o_func_wr_stb", 32'(func_wr_stb), 0);
  endtask

  initial begin
    rst            = 1'b1;
    block_mode_flg = 1'b0;
    data_cnt       = '0;
    inc_addr_flg   = 1'b0;
    cmd_address    = '0;
    activate       = 1'b0;
    mem_sel        = 1'b0;
    func_sel       = '0;
    phy_wr_stb     = 1'b0;
    phy_wr_data    = '0;
    func_rd_stb    = '0;
    func_com_rdy   = '1;
    for (int t = 0; t <= NUM_IO_FUNCS; t++) begin
      func_rd_data[t]    = sdio_data_pkg::byte_t'(160 + t);
      func_block_size[t] = sdio_data_pkg::count_t'(5 + t);
    end
    load_table();
    for (int i = 0; i < NUM_ROWS; i++) begin
      wd_cycles = wd_cycles + rows[i].exp_bytes * 4 + 100;
    end

    repeat (5) @(posedge clk);
    @(negedge clk);
    check_eq("o_finished", 32'(finished), 0);
    check_eq("o_func_hst_rdy", 32'(func_hst_rdy), 0);
    check_eq("o_address", 32'(address), 0);
    check_eq("o_total_data_cnt", 32'(total_data_cnt), 0);
    rst = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
      repeat (2) @(negedge clk);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Bounds the run by the table's total byte count
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("Timeout: a transfer did not complete within %0d cycles", wd_cycles);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/sdio_data_pkg.sv
rtl/sdio_func_channel_if.sv
rtl/sdio_func_router.sv
rtl/sdio_transfer_seq.sv
rtl/sdio_data_control.sv
sim/sdio_data_control_tb.sv
